// File: testbench/ram_model_stim.txt
# op(0 rd,1 wr) id addr wdata expected_rdata pause_cycles rsp_ready_hold
# Values in hex except the last two columns, which are decimal.
0 1 10 00000000 00000000 0 0
1 2 10 deadbeef 00000000 0 0
0 3 10 00000000 deadbeef 0 0
1 4 20 12345678 00000000 4 0
0 5 20 00000000 12345678 3 0
0 6 ff 00000000 00000000 0 2
1 7 ff cafef00d 00000000 0 3
0 8 ff 00000000 cafef00d 0 0
0 9 10 00000000 deadbeef 0 0
1 a 10 11111111 00000000 0 0
0 b 10 00000000 11111111 0 1
1 c 30 a0000001 00000000 2 40
1 d 31 a0000002 00000000 0 0
0 e 30 00000000 a0000001 0 0
1 f 32 a0000003 00000000 0 0
0 0 31 00000000 a0000002 0 0
0 1 32 00000000 a0000003 0 0
1 2 33 b0000004 00000000 0 0
0 3 33 00000000 b0000004 0 0
1 4 30 c0000005 00000000 0 0
0 5 30 00000000 c0000005 0 0
0 6 31 00000000 a0000002 0 0
0 7 99 00000000 00000000 0 0
0 8 20 00000000 12345678 0 1
0 9 ff 00000000 cafef00d 0 0
1 a 00 55aa55aa 00000000 5 0
0 b 00 00000000 55aa55aa 0 0
1 c 01 0f0f0f0f 00000000 0 2
0 d 01 00000000 0f0f0f0f 0 0
0 e 02 00000000 00000000 0 0

// File: ram_model_top.f
+incdir+hw
hw/ram_model_pkg.sv
hw/req_fork.sv
hw/resp_timing_model.sv
hw/mem_data_model.sv
hw/resp_join.sv
hw/ram_model_top.sv
testbench/ram_model_tb.sv

// File: Bender.yml
package:
  name: ram_model

sources:
  - include_dirs:
      - hw
    files:
      - hw/ram_model_pkg.sv
      - hw/req_fork.sv
      - hw/resp_timing_model.sv
      - hw/mem_data_model.sv
      - hw/resp_join.sv
      - hw/ram_model_top.sv
  - target: test
    include_dirs:
      - hw
    files:
      - testbench/ram_model_tb.sv

// File: testbench/ram_model_tb.sv
`default_nettype none

`include "ram_model_defs.svh"

module ram_model_tb;

    import ram_model_pkg::*;

    localparam int HS_TIMEOUT    = 200;
    localparam int RSP_TIMEOUT   = 400;
    localparam int DRAIN_TIMEOUT = 800;

    logic       clk;
    logic       rst_n;
    logic       pause;
    logic       req_valid;
    logic       req_ready;
    rm_req_t    req;
    logic       rsp_valid;
    logic       rsp_ready;
    rm_rsp_t    rsp;
    logic       stall;

    int unsigned cyc;
    logic        saw_full;

    // Expected responses in request order.
    logic [0:0]                 exp_op   [$];
    logic [`RM_ID_WIDTH-1:0]    exp_id   [$];
    logic [`RM_DATA_WIDTH-1:0]  exp_data [$];
    int unsigned                exp_hold [$];
    logic                       exp_lone [$];
    int unsigned                exp_cyc  [$];

    ram_model_top dut0 (
        .clk        (clk),
        .rst_n      (rst_n),
        .pause      (pause),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .rsp_valid  (rsp_valid),
        .rsp_ready  (rsp_ready),
        .rsp        (rsp),
        .stall      (stall)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #10 clk = ~clk;
        end
    end

    always @(posedge clk) begin
        cyc <= cyc + 1;
    end

    task automatic stop_on_error(input string msg);
        $display("%s", msg);
        $display("Test failed");
        $fatal(1);
    endtask

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t %s: got %h, expected %h", $time, what, got, exp);
            stop_on_error("A checked value did not match.");
        end
    endtask

    task automatic wait_for_drain(input int limit, input string where);
        int t;
        t = 0;
        while (exp_op.size() != 0) begin
            @(negedge clk);
            t++;
            if (t > limit) begin
                stop_on_error({"Outstanding responses never drained ", where, "."});
            end
        end
    endtask

    // ************************************************************
    // Request driver.
    // ************************************************************

    task automatic send_request(input logic op, input logic [3:0] id,
                                input logic [7:0] addr, input logic [31:0] wdata,
                                input logic [31:0] exp_rdata, input int pz,
                                input int hold);
        logic accepted;
        int   t;
        if (pz > 0) begin
            // Idle the request channel while earlier responses drain.
            @(negedge clk);
            req_valid = 1'b0;
            wait_for_drain(DRAIN_TIMEOUT, "before a pause");
        end
        @(negedge clk);
        req_valid = 1'b1;
        req.op    = rm_op_e'(op);
        req.id    = id;
        req.addr  = addr;
        req.wdata = wdata;
        pause     = (pz > 0);
        for (int i = 0; i < pz; i++) begin
            #1;
            check_value("stall during pause", stall, 1);
            check_value("req_ready during pause", req_ready, 0);
            check_value("rsp_valid during pause", rsp_valid, 0);
            @(negedge clk);
        end
        pause    = 1'b0;
        accepted = 1'b0;
        t        = 0;
        while (!accepted) begin
            #1;
            if (req_ready) begin
                accepted = 1'b1;
            end else begin
                if (exp_op.size() >= `RM_MAX_OUTSTANDING) begin
                    saw_full = 1'b1;
                end
                t++;
                if (t > HS_TIMEOUT) begin
                    stop_on_error("Request was never accepted by the DUT.");
                end
                @(negedge clk);
            end
        end
        exp_lone.push_back(exp_op.size() == 0);
        exp_op.push_back(op);
        exp_id.push_back(id);
        exp_data.push_back(op ? 32'h0 : exp_rdata);
        exp_hold.push_back(hold);
        exp_cyc.push_back(cyc + 1);
        @(posedge clk);
    endtask

    // ************************************************************
    // Response monitor.
    // ************************************************************

    task automatic watch_responses();
        rm_rsp_t     held;
        int unsigned hold;
        int unsigned delay;
        int          t;
        @(negedge clk);
        forever begin
            t = 0;
            while (!rsp_valid) begin
                if (exp_op.size() != 0) begin
                    t++;
                    if (t > RSP_TIMEOUT) begin
                        stop_on_error("Expected response never became valid.");
                    end
                end
                @(negedge clk);
            end
            if (exp_op.size() == 0) begin
                stop_on_error("DUT sent a response with no pending request.");
            end
            check_value("rsp op", rsp.op, exp_op[0]);
            check_value("rsp id", rsp.id, exp_id[0]);
            check_value("rsp rdata", rsp.rdata, exp_data[0]);
            if (exp_lone[0]) begin
                delay = exp_op[0] ? `RM_W_DELAY : `RM_R_DELAY;
                check_value("response latency", cyc - exp_cyc[0], delay);
            end
            held = rsp;
            hold = exp_hold[0] + ($urandom % 3);
            for (int i = 0; i < hold; i++) begin
                @(negedge clk);
                check_value("rsp_valid under back-pressure", rsp_valid, 1);
                check_value("rsp under back-pressure", rsp, held);
            end
            rsp_ready = 1'b1;
            @(negedge clk);
            rsp_ready = 1'b0;
            void'(exp_op.pop_front());
            void'(exp_id.pop_front());
            void'(exp_data.pop_front());
            void'(exp_hold.pop_front());
            void'(exp_lone.pop_front());
            void'(exp_cyc.pop_front());
        end
    endtask

    // ************************************************************
    // Main sequence.
    // ************************************************************

    initial begin
        int          fd;
        int          n;
        string       line;
        logic [31:0] f_op;
        logic [31:0] f_id;
        logic [31:0] f_addr;
        logic [31:0] f_wdata;
        logic [31:0] f_exp;
        int          f_pause;
        int          f_hold;
        rst_n     = 1'b0;
        pause     = 1'b0;
        req_valid = 1'b0;
        req       = '0;
        rsp_ready = 1'b0;
        cyc       = 0;
        saw_full  = 1'b0;
        void'($urandom(32'h1e61_11a3));
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;
        #1;
        check_value("req_ready after reset", req_ready, 0);
        check_value("rsp_valid after reset", rsp_valid, 0);
        check_value("stall after reset", stall, 0);

        fork
            watch_responses();
        join_none

        fd = $fopen("testbench/ram_model_stim.txt", "r");
        if (fd == 0) begin
            stop_on_error("Could not open the stimulus file.");
        end
        while (!$feof(fd)) begin
            line = "";
            n = $fgets(line, fd);
            if (n > 0 && line.substr(0, 0) != "#") begin
                n = $sscanf(line, "%h %h %h %h %h %d %d", f_op, f_id, f_addr,
                            f_wdata, f_exp, f_pause, f_hold);
                if (n == 7) begin
                    send_request(f_op[0], f_id[3:0], f_addr[7:0], f_wdata, f_exp,
                                 f_pause, f_hold);
                end
            end
        end
        $fclose(fd);
        @(negedge clk);
        req_valid = 1'b0;

        wait_for_drain(DRAIN_TIMEOUT, "at the end of the run");
        check_value("full queue back-pressure seen", saw_full, 1);
        $display("Test passed");
        $finish;
    end

endmodule

`default_nettype wire

// File: hw/ram_model_top.sv
`default_nettype none

`include "ram_model_defs.svh"

module ram_model_top (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             pause,

    input  wire                             req_valid,
    output logic                            req_ready,
    input  wire ram_model_pkg::rm_req_t     req,

    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output ram_model_pkg::rm_rsp_t          rsp,

    output logic                            stall
);

    import ram_model_pkg::*;

    logic                       tim_valid;
    logic                       tim_ready;
    rm_req_t                    tim_req;
    logic                       dat_valid;
    logic                       dat_ready;
    rm_req_t                    dat_req;

    logic                       due;
    rm_op_e                     due_op;
    logic [`RM_ID_WIDTH-1:0]    due_id;
    logic                       tim_pop;

    logic                       dat_rsp_valid;
    rm_rsp_t                    dat_rsp;
    logic                       dat_pop;

    // ************************************************************
    // Input side.
    // ************************************************************

    req_fork u_req_fork (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .req        (req),
        .tim_valid  (tim_valid),
        .tim_ready  (tim_ready),
        .tim_req    (tim_req),
        .dat_valid  (dat_valid),
        .dat_ready  (dat_ready),
        .dat_req    (dat_req)
    );

    // ************************************************************
    // Timing and data models.
    // ************************************************************

    resp_timing_model u_timing_model (
        .clk        (clk),
        .rst_n      (rst_n),
        .stall      (stall),
        .tim_valid  (tim_valid),
        .tim_ready  (tim_ready),
        .tim_req    (tim_req),
        .due        (due),
        .due_op     (due_op),
        .due_id     (due_id),
        .tim_pop    (tim_pop)
    );

    mem_data_model u_data_model (
        .clk            (clk),
        .rst_n          (rst_n),
        .dat_valid      (dat_valid),
        .dat_ready      (dat_ready),
        .dat_req        (dat_req),
        .dat_rsp_valid  (dat_rsp_valid),
        .dat_rsp        (dat_rsp),
        .dat_pop        (dat_pop)
    );

    // ************************************************************
    // Output side.
    // ************************************************************

    resp_join u_resp_join (
        .pause          (pause),
        .due            (due),
        .dat_rsp_valid  (dat_rsp_valid),
        .dat_rsp        (dat_rsp),
        .rsp_valid      (rsp_valid),
        .rsp_ready      (rsp_ready),
        .rsp            (rsp),
        .tim_pop        (tim_pop),
        .dat_pop        (dat_pop),
        .stall          (stall)
    );

    // Both queues must hold the same request at their heads.
    a_heads_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        rsp_valid |-> (due_id == rsp.id) && (due_op == rsp.op));

endmodule

`default_nettype wire

// File: hw/resp_join.sv
`default_nettype none

`include "ram_model_defs.svh"

module resp_join (
    input  wire                             pause,

    input  wire                             due,
    input  wire                             dat_rsp_valid,
    input  wire ram_model_pkg::rm_rsp_t     dat_rsp,

    output logic                            rsp_valid,
    input  wire                             rsp_ready,
    output ram_model_pkg::rm_rsp_t          rsp,

    output logic                            tim_pop,
    output logic                            dat_pop,
    output logic                            stall
);

    logic rsp_xfer;
    logic data_late;

    // ************************************************************
    // Response handshake.
    // ************************************************************

    // Timing decides when, data decides what.
    assign rsp_valid = due && dat_rsp_valid;
    assign rsp       = dat_rsp;

    assign rsp_xfer = rsp_valid && rsp_ready;

    // Both sides retire the same response.
    assign tim_pop = rsp_xfer;
    assign dat_pop = rsp_xfer;

    // ************************************************************
    // Stall.
    // ************************************************************

    // Timing says due, payload missing.
    assign data_late = due && !dat_rsp_valid;

    assign stall = pause || data_late;

endmodule

`default_nettype wire

// File: hw/mem_data_model.sv
`default_nettype none

`include "ram_model_defs.svh"

module mem_data_model (
    input  wire                             clk,
    input  wire                             rst_n,

    input  wire                             dat_valid,
    output logic                            dat_ready,
    input  wire ram_model_pkg::rm_req_t     dat_req,

    output logic                            dat_rsp_valid,
    output ram_model_pkg::rm_rsp_t          dat_rsp,
    input  wire                             dat_pop
);

    import ram_model_pkg::*;

    localparam int PTR_W = $clog2(`RM_MAX_OUTSTANDING);
    localparam int CNT_W = PTR_W + 1;

    logic [`RM_DATA_WIDTH-1:0]  mem [`RM_MEM_DEPTH];

    rm_rsp_t                    fifo_mem [`RM_MAX_OUTSTANDING];
    rm_rsp_t                    push_rsp;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           fifo_cnt;
    logic                       fifo_full;
    logic                       push;

    assign fifo_full = (fifo_cnt == CNT_W'(`RM_MAX_OUTSTANDING));
    assign dat_ready = !fifo_full;
    assign push      = dat_valid && dat_ready;

    // ************************************************************
    // Memory array.
    // ************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < `RM_MEM_DEPTH; i++) begin
                mem[i] <= '0;
            end
        end else if (push && dat_req.op == RM_OP_WRITE) begin
            mem[dat_req.addr] <= dat_req.wdata;
        end
    end

    // Reads see every write accepted before them.
    always_comb begin
        push_rsp.op    = dat_req.op;
        push_rsp.id    = dat_req.id;
        push_rsp.rdata = (dat_req.op == RM_OP_READ) ? mem[dat_req.addr] : '0;
    end

    // ************************************************************
    // Response FIFO.
    // ************************************************************

    always_ff @(posedge clk) begin
        if (push) begin
            fifo_mem[wr_ptr] <= push_rsp;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            fifo_cnt <= '0;
        end else begin
            if (push) begin
                wr_ptr <= wr_ptr + PTR_W'(1);
            end
            if (dat_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, dat_pop})
                2'b10:   fifo_cnt <= fifo_cnt + CNT_W'(1);
                2'b01:   fifo_cnt <= fifo_cnt - CNT_W'(1);
                default: fifo_cnt <= fifo_cnt;
            endcase
        end
    end

    assign dat_rsp_valid = (fifo_cnt != '0);
    assign dat_rsp       = fifo_mem[rd_ptr];

    // A full FIFO only drains.
    a_no_push_full: assert property (@(posedge clk) disable iff (!rst_n)
        fifo_full && !dat_pop |=> fifo_full);

endmodule

`default_nettype wire

// File: hw/resp_timing_model.sv
`default_nettype none

`include "ram_model_defs.svh"

module resp_timing_model (
    input  wire                             clk,
    input  wire                             rst_n,
    input  wire                             stall,

    input  wire                             tim_valid,
    output logic                            tim_ready,
    input  wire ram_model_pkg::rm_req_t     tim_req,

    output logic                            due,
    output ram_model_pkg::rm_op_e           due_op,
    output logic [`RM_ID_WIDTH-1:0]         due_id,
    input  wire                             tim_pop
);

    import ram_model_pkg::*;

    localparam int TIME_W = `RM_TIME_WIDTH;
    localparam int PTR_W  = $clog2(`RM_MAX_OUTSTANDING);
    localparam int CNT_W  = PTR_W + 1;

    logic [TIME_W-1:0]          cycle_cnt;
    logic [TIME_W-1:0]          last_due;
    logic [TIME_W-1:0]          op_delay;
    logic [TIME_W-1:0]          base_due;
    logic [TIME_W-1:0]          order_due;
    logic signed [TIME_W-1:0]   order_gap;
    logic [TIME_W-1:0]          next_due;
    logic [TIME_W-1:0]          head_gap;

    rm_ticket_t                 tq_mem [`RM_MAX_OUTSTANDING];
    rm_ticket_t                 head;
    rm_ticket_t                 new_ticket;
    logic [PTR_W-1:0]           wr_ptr;
    logic [PTR_W-1:0]           rd_ptr;
    logic [CNT_W-1:0]           tq_cnt;
    logic                       tq_empty;
    logic                       push;

    // ************************************************************
    // Cycle counter, frozen while the DUT is stalled.
    // ************************************************************

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cycle_cnt <= '0;
        end else if (!stall) begin
            cycle_cnt <= cycle_cnt + TIME_W'(1);
        end
    end

    // ************************************************************
    // Due time of an incoming request.
    // ************************************************************

    // Counted from the value the accepting edge advances to.
    assign op_delay  = (tim_req.op == RM_OP_READ) ? TIME_W'(`RM_R_DELAY)
                                                  : TIME_W'(`RM_W_DELAY);
    assign base_due  = cycle_cnt + TIME_W'(1) + op_delay;
    assign order_due = last_due + TIME_W'(1);
    assign order_gap = order_due - base_due;

    // Never earlier than the ticket ahead of it.
    assign next_due = (!tq_empty && order_gap > 0) ? order_due : base_due;

    assign new_ticket = '{op: tim_req.op, id: tim_req.id, due: next_due};

    // ************************************************************
    // Ticket queue.
    // ************************************************************

    assign tq_empty  = (tq_cnt == '0);
    assign tim_ready = (tq_cnt < CNT_W'(`RM_MAX_OUTSTANDING));
    assign push      = tim_valid && tim_ready;

    always_ff @(posedge clk) begin
        if (push) begin
            tq_mem[wr_ptr] <= new_ticket;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            tq_cnt   <= '0;
            last_due <= '0;
        end else begin
            if (push) begin
                wr_ptr   <= wr_ptr + PTR_W'(1);
                last_due <= next_due;
            end
            if (tim_pop) begin
                rd_ptr <= rd_ptr + PTR_W'(1);
            end
            case ({push, tim_pop})
                2'b10:   tq_cnt <= tq_cnt + CNT_W'(1);
                2'b01:   tq_cnt <= tq_cnt - CNT_W'(1);
                default: tq_cnt <= tq_cnt;
            endcase
        end
    end

    assign head = tq_mem[rd_ptr];

    // Head is due once the count has reached its time.
    assign head_gap = cycle_cnt - head.due;
    assign due      = !tq_empty && !head_gap[TIME_W-1];
    assign due_op   = head.op;
    assign due_id   = head.id;

    a_pop_when_due: assert property (@(posedge clk) disable iff (!rst_n)
        tim_pop |-> due);

endmodule

`default_nettype wire

// File: hw/req_fork.sv
`default_nettype none

`include "ram_model_defs.svh"

module req_fork (
    input  wire                         clk,
    input  wire                         rst_n,
    input  wire                         stall,

    input  wire                         req_valid,
    output logic                        req_ready,
    input  wire ram_model_pkg::rm_req_t req,

    output logic                        tim_valid,
    input  wire                         tim_ready,
    output ram_model_pkg::rm_req_t      tim_req,

    output logic                        dat_valid,
    input  wire                         dat_ready,
    output ram_model_pkg::rm_req_t      dat_req
);

    logic tim_done;
    logic dat_done;
    logic req_xfer;

    // Offer only to branches that have not taken this request yet.
    assign tim_valid = req_valid && !tim_done && !stall;
    assign dat_valid = req_valid && !dat_done && !stall;

    assign tim_req = req;
    assign dat_req = req;

    assign req_ready = req_valid && !stall &&
                       (tim_done || tim_ready) &&
                       (dat_done || dat_ready);

    assign req_xfer = req_valid && req_ready;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            tim_done <= 1'b0;
            dat_done <= 1'b0;
        end else if (req_xfer) begin
            tim_done <= 1'b0;
            dat_done <= 1'b0;
        end else begin
            if (tim_valid && tim_ready) begin
                tim_done <= 1'b1;
            end
            if (dat_valid && dat_ready) begin
                dat_done <= 1'b1;
            end
        end
    end

    // DUT holds its request until accepted.
    a_req_stable: assert property (@(posedge clk) disable iff (!rst_n)
        req_valid && !req_ready |=> req_valid && $stable(req));

endmodule

`default_nettype wire

// File: hw/ram_model_pkg.sv
`default_nettype none

`include "ram_model_defs.svh"

package ram_model_pkg;

    typedef enum logic {
        RM_OP_READ  = 1'b0,
        RM_OP_WRITE = 1'b1
    } rm_op_e;

    // Request as sent by the DUT.
    typedef struct packed {
        rm_op_e                     op;
        logic [`RM_ID_WIDTH-1:0]    id;
        logic [`RM_ADDR_WIDTH-1:0]  addr;
        logic [`RM_DATA_WIDTH-1:0]  wdata;
    } rm_req_t;

    // Response back to the DUT, rdata is zero for writes.
    typedef struct packed {
        rm_op_e                     op;
        logic [`RM_ID_WIDTH-1:0]    id;
        logic [`RM_DATA_WIDTH-1:0]  rdata;
    } rm_rsp_t;

    // One entry of the timing queue.
    typedef struct packed {
        rm_op_e                     op;
        logic [`RM_ID_WIDTH-1:0]    id;
        logic [`RM_TIME_WIDTH-1:0]  due;
    } rm_ticket_t;

endpackage

`default_nettype wire

// File: hw/ram_model_defs.svh
`ifndef RAM_MODEL_DEFS_SVH
`define RAM_MODEL_DEFS_SVH

// ************************************************************
// Widths.
// ************************************************************

`define RM_ADDR_WIDTH       8
`define RM_DATA_WIDTH       32
`define RM_ID_WIDTH         4
`define RM_TIME_WIDTH       16

// ************************************************************
// Memory geometry and latency.
// ************************************************************

`define RM_MEM_DEPTH        256

// Unstalled cycles from request to response.
`define RM_R_DELAY          6
`define RM_W_DELAY          3

// Ticket queue and response FIFO depth.
`define RM_MAX_OUTSTANDING  8

`endif
